//--- mem_tester.f
common/mem_tester_pkg.sv
hdl/test_dispatch.sv
mem_engine/mem_test_engine.sv
hdl/wb_rr_arbiter.sv
hdl/wb_test_ram.sv
hdl/mem_tester_top.sv
tb/tb_mem_tester.sv

//--- Makefile
# Verilator build and run for the memory tester

VERILATOR ?= verilator
TOP       ?= tb_mem_tester
FILELIST  ?= mem_tester.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_mem_tester.sv
`timescale 1ns/10ps

module tb_mem_tester;

   localparam int N_ENGINES = 4;
   localparam int ADDR_W    = 10;
   localparam int DATA_W    = 32;
   localparam int ENG_W     = mem_tester_pkg::idx_w(N_ENGINES);
   localparam int ERR_W     = mem_tester_pkg::ERR_W;
   localparam int DEPTH     = 2**ADDR_W;

   logic                       clk;
   logic                       arst_n;
   logic                       cmd_valid;
   mem_tester_pkg::test_op_e   cmd_op;
   logic [ENG_W-1:0]           cmd_engine;
   logic [ADDR_W-1:0]          cmd_base;
   logic [ADDR_W-1:0]          cmd_len;
   logic [DATA_W-1:0]          cmd_pattern;
   logic                       cmd_ready;
   logic [DATA_W-1:0]          fault_mask;
   logic [N_ENGINES-1:0]       done;
   logic [N_ENGINES-1:0]       fail;
   logic [N_ENGINES*ERR_W-1:0] err_count;
   logic                       trap;

   logic [DATA_W-1:0] model_mem [DEPTH];  // Expected RAM contents
   logic [31:0]       lfsr_q;
   int                done_cnt [N_ENGINES];
   int                exp_done [N_ENGINES];
   int                cycle_cnt   = 0;
   int                cycle_limit = 300;  // Grows with every command
   int                checks      = 0;
   int                errors      = 0;

   mem_tester_top #(
      .N_ENGINES (N_ENGINES),
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W)
   ) mem_tester_top_inst (
      .clk         (clk),
      .arst_n      (arst_n),
      .cmd_valid   (cmd_valid),
      .cmd_op      (cmd_op),
      .cmd_engine  (cmd_engine),
      .cmd_base    (cmd_base),
      .cmd_len     (cmd_len),
      .cmd_pattern (cmd_pattern),
      .cmd_ready   (cmd_ready),
      .fault_mask  (fault_mask),
      .done        (done),
      .fail        (fail),
      .err_count   (err_count),
      .trap        (trap)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Watchdog
   initial begin
      while (cycle_cnt <= cycle_limit) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
   end

   // Done pulses per engine
   always @(negedge clk) begin
      for (int i = 0; i < N_ENGINES; i++) begin
         if (!arst_n) begin
            done_cnt[i] = 0;
         end else if (done[i]) begin
            done_cnt[i]++;
         end
      end
   end

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        lsb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lsb    = lfsr_q[0];
         lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lsb ? 32'h8020_0003 : 32'h0);
         val    = {val[30:0], lsb};
      end
      return val;
   endfunction

   function automatic logic [ERR_W-1:0] count_of(input int eng);
      return err_count[eng*ERR_W +: ERR_W];
   endfunction

   task automatic compare_count(input logic [mem_tester_pkg::ERR_W-1:0] got,
                                input logic [mem_tester_pkg::ERR_W-1:0] exp,
                                input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic compare_flag(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // Word i of a range sits at base + i and holds pattern + i
   task automatic apply_fill(input logic [ADDR_W-1:0] base, input logic [ADDR_W-1:0] len,
                             input logic [DATA_W-1:0] pattern);
      for (int i = 0; i <= int'(len); i++) begin
         model_mem[base + ADDR_W'(i)] = pattern + DATA_W'(i);
      end
   endtask

   function automatic int predict_errors(input logic [ADDR_W-1:0] base,
                                         input logic [ADDR_W-1:0] len,
                                         input logic [DATA_W-1:0] pattern);
      int n;
      n = 0;
      for (int i = 0; i <= int'(len); i++) begin
         if (model_mem[base + ADDR_W'(i)] !== pattern + DATA_W'(i)) begin
            n++;
         end
      end
      return n;
   endfunction

   // Returns the number of cycles the command waited for cmd_ready
   task automatic send_cmd(input mem_tester_pkg::test_op_e op, input int eng,
                           input logic [ADDR_W-1:0] base, input logic [ADDR_W-1:0] len,
                           input logic [DATA_W-1:0] pattern, output int waited);
      waited = 0;
      @(negedge clk);
      cmd_valid   = 1'b1;
      cmd_op      = op;
      cmd_engine  = ENG_W'(eng);
      cmd_base    = base;
      cmd_len     = len;
      cmd_pattern = pattern;
      #1;
      while (!cmd_ready) begin
         @(negedge clk);
         #1;
         waited++;
      end
      @(posedge clk);  // Transfer edge
      exp_done[eng]++;
      // Two passes, three cycles per word, every engine competing
      cycle_limit += (int'(len) + 1) * 2 * 3 * N_ENGINES + 50;
      @(negedge clk);
      cmd_valid = 1'b0;
   endtask

   task automatic wait_done(input int eng);
      while (done_cnt[eng] < exp_done[eng]) begin
         @(posedge clk);
      end
      @(negedge clk);
   endtask

   task automatic report_test(input string name, input int errors_before);
      $display("%s: %0d failing checks", name, errors - errors_before);
   endtask

   // ------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------

   task automatic check_clean_fill();
      int                e0;
      int                w;
      logic [ADDR_W-1:0] base;
      logic [DATA_W-1:0] pat;
      e0   = errors;
      base = ADDR_W'(DEPTH - 8);  // Range wraps past the top
      pat  = DATA_W'(rand_bits(DATA_W));
      send_cmd(mem_tester_pkg::OP_FILL_CHECK, 0, base, 10'd15, pat, w);
      wait_done(0);
      apply_fill(base, 10'd15, pat);
      compare_count(count_of(0), '0, "engine 0 err_count");
      compare_flag(fail[0], 1'b0, "engine 0 fail");
      compare_flag(trap, 1'b0, "trap");
      report_test("fill_check", e0);
   endtask

   task automatic inject_read_faults();
      int                e0;
      int                w;
      logic [ADDR_W-1:0] base;
      logic [ADDR_W-1:0] len;
      logic [DATA_W-1:0] pat;
      e0   = errors;
      base = ADDR_W'(rand_bits(ADDR_W));
      len  = ADDR_W'(rand_bits(5));
      pat  = DATA_W'(rand_bits(DATA_W));
      send_cmd(mem_tester_pkg::OP_FILL, 1, base, len, pat, w);
      wait_done(1);
      apply_fill(base, len, pat);
      fault_mask = DATA_W'(rand_bits(DATA_W)) | DATA_W'(1);
      send_cmd(mem_tester_pkg::OP_CHECK, 1, base, len, pat, w);
      wait_done(1);
      compare_count(count_of(1), ERR_W'(int'(len) + 1), "engine 1 err_count, faulty");
      compare_flag(fail[1], 1'b1, "engine 1 fail, faulty");
      compare_flag(trap, 1'b1, "trap, faulty");
      fault_mask = '0;
      send_cmd(mem_tester_pkg::OP_CHECK, 1, base, len, pat, w);
      wait_done(1);
      compare_count(count_of(1), '0, "engine 1 err_count, recheck");
      compare_flag(fail[1], 1'b0, "engine 1 fail, recheck");
      compare_flag(trap, 1'b0, "trap, recheck");
      report_test("read_faults", e0);
   endtask

   task automatic fill_all_engines();
      int                e0;
      int                w;
      int                slice;
      logic [ADDR_W-1:0] base [N_ENGINES];
      logic [ADDR_W-1:0] len  [N_ENGINES];
      logic [DATA_W-1:0] pat  [N_ENGINES];
      e0    = errors;
      slice = DEPTH / N_ENGINES;
      for (int e = 0; e < N_ENGINES; e++) begin
         base[e] = ADDR_W'(e * slice) + ADDR_W'(rand_bits(ADDR_W) % (slice / 2));
         len[e]  = ADDR_W'(rand_bits(ADDR_W) % (slice / 4));
         pat[e]  = DATA_W'(rand_bits(DATA_W));
      end
      for (int e = 0; e < N_ENGINES; e++) begin
         send_cmd(mem_tester_pkg::OP_FILL, e, base[e], len[e], pat[e], w);
      end
      for (int e = 0; e < N_ENGINES; e++) begin
         wait_done(e);
         apply_fill(base[e], len[e], pat[e]);
      end
      for (int e = 0; e < N_ENGINES; e++) begin
         send_cmd(mem_tester_pkg::OP_CHECK, e, base[e], len[e], pat[e], w);
      end
      for (int e = 0; e < N_ENGINES; e++) begin
         wait_done(e);
      end
      repeat (4) @(negedge clk);  // Catch any stray done
      for (int e = 0; e < N_ENGINES; e++) begin
         compare_count(count_of(e), '0, $sformatf("engine %0d err_count", e));
         compare_flag(fail[e], 1'b0, $sformatf("engine %0d fail", e));
         compare_count(ERR_W'(done_cnt[e]), ERR_W'(exp_done[e]),
                       $sformatf("engine %0d done pulses", e));
      end
      compare_flag(trap, 1'b0, "trap, concurrent");
      report_test("concurrent", e0);
   endtask

   task automatic overlap_ranges();
      int                e0;
      int                w;
      int                exp;
      logic [ADDR_W-1:0] base_a;
      logic [ADDR_W-1:0] base_b;
      logic [DATA_W-1:0] pat_a;
      logic [DATA_W-1:0] pat_b;
      e0     = errors;
      base_a = ADDR_W'(rand_bits(ADDR_W));
      base_b = base_a + 10'd8 + ADDR_W'(rand_bits(4));
      pat_a  = DATA_W'(rand_bits(DATA_W));
      pat_b  = ~pat_a;
      send_cmd(mem_tester_pkg::OP_FILL, 0, base_a, 10'd31, pat_a, w);
      wait_done(0);
      apply_fill(base_a, 10'd31, pat_a);
      send_cmd(mem_tester_pkg::OP_FILL, 1, base_b, 10'd31, pat_b, w);
      wait_done(1);
      apply_fill(base_b, 10'd31, pat_b);
      exp = predict_errors(base_a, 10'd31, pat_a);
      send_cmd(mem_tester_pkg::OP_CHECK, 0, base_a, 10'd31, pat_a, w);
      wait_done(0);
      compare_count(count_of(0), ERR_W'(exp), "engine 0 err_count, overlap");
      compare_flag(fail[0], exp != 0, "engine 0 fail, overlap");
      compare_flag(trap, exp != 0, "trap, overlap");
      report_test("overlap", e0);
   endtask

   task automatic hold_off_busy();
      int                e0;
      int                w;
      logic [DATA_W-1:0] pat;
      e0  = errors;
      pat = DATA_W'(rand_bits(DATA_W));
      send_cmd(mem_tester_pkg::OP_FILL_CHECK, 0, 10'd0, 10'd40, pat, w);
      send_cmd(mem_tester_pkg::OP_FILL, 1, ADDR_W'(DEPTH / 2), 10'd20, ~pat, w);
      compare_flag(w == 0, 1'b1, "idle engine 1 accepted at once");
      send_cmd(mem_tester_pkg::OP_CHECK, 0, 10'd0, 10'd40, pat, w);
      compare_flag(w > 0, 1'b1, "busy engine 0 held off");
      compare_flag(done_cnt[0] == exp_done[0] - 1, 1'b1, "engine 0 done before accept");
      wait_done(0);
      wait_done(1);
      apply_fill(10'd0, 10'd40, pat);
      apply_fill(ADDR_W'(DEPTH / 2), 10'd20, ~pat);
      compare_count(count_of(0), ERR_W'(predict_errors(10'd0, 10'd40, pat)),
                    "engine 0 err_count, back-pressure");
      report_test("back_pressure", e0);
   endtask

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------

   initial begin
      arst_n      = 1'b0;
      cmd_valid   = 1'b0;
      cmd_op      = mem_tester_pkg::OP_NONE;
      cmd_engine  = '0;
      cmd_base    = '0;
      cmd_len     = '0;
      cmd_pattern = '0;
      fault_mask  = '0;
      lfsr_q      = 32'h183df170;
      repeat (16) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      repeat (4) @(negedge clk);  // Let the reset synchronizer release
      compare_flag(|done, 1'b0, "done after reset");
      compare_flag(trap, 1'b0, "trap after reset");
      check_clean_fill();
      inject_read_faults();
      fill_all_engines();
      overlap_ranges();
      hold_off_busy();
      $display("checks: %0d, failing: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- hdl/mem_tester_top.sv
`timescale 1ns/10ps

module mem_tester_top #(
   parameter int N_ENGINES = 4,
   parameter int ADDR_W    = 10,
   parameter int DATA_W    = 32,
   localparam int ENG_W    = mem_tester_pkg::idx_w(N_ENGINES),
   localparam int ERR_W    = mem_tester_pkg::ERR_W
) (
   input  logic                       clk,
   input  logic                       arst_n,

   // Command port
   input  logic                       cmd_valid,
   input  mem_tester_pkg::test_op_e   cmd_op,
   input  logic [ENG_W-1:0]           cmd_engine,
   input  logic [ADDR_W-1:0]          cmd_base,
   input  logic [ADDR_W-1:0]          cmd_len,
   input  logic [DATA_W-1:0]          cmd_pattern,
   output logic                       cmd_ready,

   input  logic [DATA_W-1:0]          fault_mask,

   // Per-engine results
   output logic [N_ENGINES-1:0]       done,
   output logic [N_ENGINES-1:0]       fail,
   output logic [N_ENGINES*ERR_W-1:0] err_count,
   output logic                       trap
);

   // ------------------------------------------------------------
   // Reset synchronizer
   // ------------------------------------------------------------

   logic [1:0] rst_sync_q;
   logic       rst_n;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rst_sync_q <= 2'b00;
      end else begin
         rst_sync_q <= {rst_sync_q[0], 1'b1};  // Release after two edges
      end
   end

   assign rst_n = rst_sync_q[1];

   logic [N_ENGINES-1:0]        busy;
   logic [N_ENGINES-1:0]        start;
   mem_tester_pkg::test_op_e    eng_op;
   logic [ADDR_W-1:0]           eng_base;
   logic [ADDR_W-1:0]           eng_len;
   logic [DATA_W-1:0]           eng_pattern;

   // Engine bus ports
   logic [N_ENGINES-1:0]        m_cyc;
   logic [N_ENGINES-1:0]        m_stb;
   logic [N_ENGINES-1:0]        m_we;
   logic [N_ENGINES*ADDR_W-1:0] m_adr;
   logic [N_ENGINES*DATA_W-1:0] m_dat_w;
   logic [N_ENGINES-1:0]        m_ack;
   logic [DATA_W-1:0]           m_dat_r;

   // Shared RAM bus
   logic                        s_cyc;
   logic                        s_stb;
   logic                        s_we;
   logic [ADDR_W-1:0]           s_adr;
   logic [DATA_W-1:0]           s_dat_w;
   logic                        s_ack;
   logic [DATA_W-1:0]           s_dat_r;

   test_dispatch #(
      .N_ENGINES (N_ENGINES),
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W)
   ) dispatch_inst (
      .clk         (clk),
      .arst_n      (rst_n),
      .cmd_valid   (cmd_valid),
      .cmd_op      (cmd_op),
      .cmd_engine  (cmd_engine),
      .cmd_base    (cmd_base),
      .cmd_len     (cmd_len),
      .cmd_pattern (cmd_pattern),
      .cmd_ready   (cmd_ready),
      .busy        (busy),
      .start       (start),
      .eng_op      (eng_op),
      .eng_base    (eng_base),
      .eng_len     (eng_len),
      .eng_pattern (eng_pattern)
   );

   for (genvar g = 0; g < N_ENGINES; g++) begin : g_engine
      mem_test_engine #(
         .ADDR_W (ADDR_W),
         .DATA_W (DATA_W)
      ) engine_inst (
         .clk       (clk),
         .arst_n    (rst_n),
         .start     (start[g]),
         .op        (eng_op),
         .base      (eng_base),
         .len       (eng_len),
         .pattern   (eng_pattern),
         .busy      (busy[g]),
         .done      (done[g]),
         .fail      (fail[g]),
         .err_count (err_count[g*ERR_W +: ERR_W]),
         .wb_cyc    (m_cyc[g]),
         .wb_stb    (m_stb[g]),
         .wb_we     (m_we[g]),
         .wb_adr    (m_adr[g*ADDR_W +: ADDR_W]),
         .wb_dat_w  (m_dat_w[g*DATA_W +: DATA_W]),
         .wb_ack    (m_ack[g]),
         .wb_dat_r  (m_dat_r)
      );
   end

   wb_rr_arbiter #(
      .N_ENGINES (N_ENGINES),
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W)
   ) arbiter_inst (
      .clk     (clk),
      .arst_n  (rst_n),
      .m_cyc   (m_cyc),
      .m_stb   (m_stb),
      .m_we    (m_we),
      .m_adr   (m_adr),
      .m_dat_w (m_dat_w),
      .m_ack   (m_ack),
      .m_dat_r (m_dat_r),
      .s_cyc   (s_cyc),
      .s_stb   (s_stb),
      .s_we    (s_we),
      .s_adr   (s_adr),
      .s_dat_w (s_dat_w),
      .s_ack   (s_ack),
      .s_dat_r (s_dat_r)
   );

   wb_test_ram #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) ram_inst (
      .clk        (clk),
      .arst_n     (rst_n),
      .cyc        (s_cyc),
      .stb        (s_stb),
      .we         (s_we),
      .adr        (s_adr),
      .dat_w      (s_dat_w),
      .ack        (s_ack),
      .dat_r      (s_dat_r),
      .fault_mask (fault_mask)
   );

   // Any failing engine raises trap
   assign trap = |fail;

endmodule

//--- hdl/wb_test_ram.sv
`timescale 1ns/10ps

module wb_test_ram #(
   parameter int ADDR_W = 10,
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              arst_n,

   // Wishbone classic slave
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  logic [ADDR_W-1:0] adr,
   input  logic [DATA_W-1:0] dat_w,
   output logic              ack,
   output logic [DATA_W-1:0] dat_r,

   // Read error injection
   input  logic [DATA_W-1:0] fault_mask
);

   logic [DATA_W-1:0] mem [2**ADDR_W];
   logic [DATA_W-1:0] rd_q;
   logic              req;

   // New request only, so ack stays a single cycle
   assign req = cyc && stb && !ack;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ack <= 1'b0;
      end else begin
         ack <= req;
      end
   end

   // ------------------------------------------------------------
   // Storage
   // ------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (req) begin
         if (we) begin
            mem[adr] <= dat_w;
         end
         rd_q <= mem[adr];  // Valid alongside ack
      end
   end

   // Fault mask only corrupts the returned word
   assign dat_r = rd_q ^ fault_mask;

endmodule

//--- hdl/wb_rr_arbiter.sv
`timescale 1ns/10ps

module wb_rr_arbiter #(
   parameter int N_ENGINES = 4,
   parameter int ADDR_W    = 10,
   parameter int DATA_W    = 32,
   localparam int GNT_W    = mem_tester_pkg::idx_w(N_ENGINES)
) (
   input  logic                          clk,
   input  logic                          arst_n,

   // Master ports, packed per master
   input  logic [N_ENGINES-1:0]          m_cyc,
   input  logic [N_ENGINES-1:0]          m_stb,
   input  logic [N_ENGINES-1:0]          m_we,
   input  logic [N_ENGINES*ADDR_W-1:0]   m_adr,
   input  logic [N_ENGINES*DATA_W-1:0]   m_dat_w,
   output logic [N_ENGINES-1:0]          m_ack,
   output logic [DATA_W-1:0]             m_dat_r,

   // Slave port
   output logic                          s_cyc,
   output logic                          s_stb,
   output logic                          s_we,
   output logic [ADDR_W-1:0]             s_adr,
   output logic [DATA_W-1:0]             s_dat_w,
   input  logic                          s_ack,
   input  logic [DATA_W-1:0]             s_dat_r
);

   logic [GNT_W-1:0] grant_q;   // Last master granted
   logic             locked_q;  // Granted cycle was live last clock
   logic [GNT_W-1:0] pick;
   logic [GNT_W-1:0] gnt;
   logic             hold;

   // Keep the owner while its cycle stays up
   assign hold = locked_q && m_cyc[grant_q];

   // Round-robin search starting after the last owner
   always_comb begin
      int cand;
      pick = grant_q;
      // Walk backwards so the nearest requester wins
      for (int i = N_ENGINES; i >= 1; i--) begin
         cand = (int'(grant_q) + i) % N_ENGINES;
         if (m_cyc[cand]) begin
            pick = GNT_W'(cand);
         end
      end
   end

   assign gnt = hold ? grant_q : pick;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         grant_q  <= '0;
         locked_q <= 1'b0;
      end else begin
         locked_q <= s_cyc;
         if (s_cyc) begin
            grant_q <= gnt;
         end
      end
   end

   // ------------------------------------------------------------
   // Data path mux
   // ------------------------------------------------------------

   assign s_cyc   = m_cyc[gnt];
   assign s_stb   = m_stb[gnt];
   assign s_we    = m_we[gnt];
   assign s_adr   = m_adr[gnt*ADDR_W +: ADDR_W];
   assign s_dat_w = m_dat_w[gnt*DATA_W +: DATA_W];
   assign m_dat_r = s_dat_r;  // Broadcast, qualified by ack

   always_comb begin
      m_ack      = '0;
      m_ack[gnt] = s_ack;
   end

   // Slave ack lands on the master that held the bus a cycle earlier
   a_ack_owner: assert property (
      @(posedge clk) disable iff (!arst_n)
      s_ack |-> locked_q && m_cyc[grant_q]
                && (m_ack == (N_ENGINES'(1) << grant_q))
   );

endmodule

//--- mem_engine/mem_test_engine.sv
`timescale 1ns/10ps

module mem_test_engine #(
   parameter int ADDR_W = 10,
   parameter int DATA_W = 32
) (
   input  logic                             clk,
   input  logic                             arst_n,

   // Command from dispatcher
   input  logic                             start,
   input  mem_tester_pkg::test_op_e         op,
   input  logic [ADDR_W-1:0]                base,
   input  logic [ADDR_W-1:0]                len,
   input  logic [DATA_W-1:0]                pattern,

   // Status
   output logic                             busy,
   output logic                             done,
   output logic                             fail,
   output logic [mem_tester_pkg::ERR_W-1:0] err_count,

   // Wishbone classic master
   output logic                             wb_cyc,
   output logic                             wb_stb,
   output logic                             wb_we,
   output logic [ADDR_W-1:0]                wb_adr,
   output logic [DATA_W-1:0]                wb_dat_w,
   input  logic                             wb_ack,
   input  logic [DATA_W-1:0]                wb_dat_r
);

   mem_tester_pkg::engine_state_e state;
   mem_tester_pkg::test_op_e      op_q;
   logic [ADDR_W-1:0]             base_q;
   logic [ADDR_W-1:0]             len_q;
   logic [DATA_W-1:0]             pattern_q;
   logic [ADDR_W-1:0]             idx;  // Word offset in range
   logic [DATA_W-1:0]             expect_word;
   logic                          last_word;

   // Word i lives at base + i and holds pattern + i
   assign wb_adr      = base_q + idx;
   assign expect_word = pattern_q + DATA_W'(idx);
   assign wb_dat_w    = expect_word;
   assign wb_we       = (state == mem_tester_pkg::ST_WRITE);
   assign last_word   = (idx == len_q);  // len 0 is a single word
   assign done        = (state == mem_tester_pkg::ST_DONE);

   // Command latch
   always_ff @(posedge clk) begin
      if (start) begin
         op_q      <= op;
         base_q    <= base;
         len_q     <= len;
         pattern_q <= pattern;
      end
   end

   // ------------------------------------------------------------
   // Control FSM and bus requests
   // ------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= mem_tester_pkg::ST_IDLE;
         idx       <= '0;
         wb_cyc    <= 1'b0;
         wb_stb    <= 1'b0;
         busy      <= 1'b0;
         fail      <= 1'b0;
         err_count <= '0;
      end else begin
         busy <= (state != mem_tester_pkg::ST_IDLE);  // Lags state by a cycle
         case (state)
            mem_tester_pkg::ST_IDLE: begin
               if (start) begin
                  idx       <= '0;
                  fail      <= 1'b0;  // New command clears results
                  err_count <= '0;
                  case (op)
                     mem_tester_pkg::OP_FILL,
                     mem_tester_pkg::OP_FILL_CHECK: state <= mem_tester_pkg::ST_WRITE;
                     mem_tester_pkg::OP_CHECK:      state <= mem_tester_pkg::ST_READ;
                     default:                       state <= mem_tester_pkg::ST_DONE;
                  endcase
               end
            end
            mem_tester_pkg::ST_WRITE: begin
               if (!wb_cyc) begin
                  wb_cyc <= 1'b1;
                  wb_stb <= 1'b1;
               end else if (wb_ack) begin
                  wb_cyc <= 1'b0;  // At least one idle cycle between words
                  wb_stb <= 1'b0;
                  if (last_word) begin
                     idx   <= '0;
                     state <= (op_q == mem_tester_pkg::OP_FILL_CHECK) ?
                              mem_tester_pkg::ST_READ : mem_tester_pkg::ST_DONE;
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
            end
            mem_tester_pkg::ST_READ: begin
               if (!wb_cyc) begin
                  wb_cyc <= 1'b1;
                  wb_stb <= 1'b1;
               end else if (wb_ack) begin
                  wb_cyc <= 1'b0;
                  wb_stb <= 1'b0;
                  if (wb_dat_r != expect_word) begin
                     fail <= 1'b1;  // Sticky until next start
                     if (err_count != '1) begin
                        err_count <= err_count + 1'b1;
                     end
                  end
                  if (last_word) begin
                     state <= mem_tester_pkg::ST_DONE;
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
            end
            mem_tester_pkg::ST_DONE: state <= mem_tester_pkg::ST_IDLE;
            default:                 state <= mem_tester_pkg::ST_IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------

   // Request and its payload held until the slave answers
   a_req_held: assert property (
      @(posedge clk) disable iff (!arst_n)
      (wb_stb && !wb_ack) |=> wb_stb && $stable(wb_adr) && $stable(wb_we)
                              && $stable(wb_dat_w)
   );

   // Dispatcher must wait for this engine to go idle
   a_start_idle: assert property (
      @(posedge clk) disable iff (!arst_n)
      start |-> !busy && (state == mem_tester_pkg::ST_IDLE)
   );

endmodule

//--- hdl/test_dispatch.sv
`timescale 1ns/10ps

module test_dispatch #(
   parameter int N_ENGINES = 4,
   parameter int ADDR_W    = 10,
   parameter int DATA_W    = 32,
   localparam int ENG_W    = mem_tester_pkg::idx_w(N_ENGINES)
) (
   input  logic                     clk,
   input  logic                     arst_n,

   // External command port
   input  logic                     cmd_valid,
   input  mem_tester_pkg::test_op_e cmd_op,
   input  logic [ENG_W-1:0]         cmd_engine,
   input  logic [ADDR_W-1:0]        cmd_base,
   input  logic [ADDR_W-1:0]        cmd_len,
   input  logic [DATA_W-1:0]        cmd_pattern,
   output logic                     cmd_ready,

   // Engine side
   input  logic [N_ENGINES-1:0]     busy,
   output logic [N_ENGINES-1:0]     start,
   output mem_tester_pkg::test_op_e eng_op,
   output logic [ADDR_W-1:0]        eng_base,
   output logic [ADDR_W-1:0]        eng_len,
   output logic [DATA_W-1:0]        eng_pattern
);

   logic [N_ENGINES-1:0] sel;
   logic [N_ENGINES-1:0] pend_q;  // Start from last cycle, busy not yet up
   logic                 accept;

   // Engine select decode, out of range selects nothing
   always_comb begin
      sel = '0;
      if (int'(cmd_engine) < N_ENGINES) begin
         sel[cmd_engine] = 1'b1;
      end
   end

   // Addressed engine must be idle with no start in flight
   assign cmd_ready = ~|(sel & (busy | start | pend_q));
   assign accept    = cmd_valid & cmd_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         start  <= '0;
         pend_q <= '0;
      end else begin
         pend_q <= start;
         // OP_NONE is taken off the port but never reaches an engine
         start  <= (accept && cmd_op != mem_tester_pkg::OP_NONE) ? sel : '0;
      end
   end

   // Shared argument registers, engines latch them on their start
   always_ff @(posedge clk) begin
      if (accept) begin
         eng_op      <= cmd_op;
         eng_base    <= cmd_base;
         eng_len     <= cmd_len;
         eng_pattern <= cmd_pattern;
      end
   end

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------

   // Busy must cover the engine once its pending window closes
   a_busy_follows: assert property (
      @(posedge clk) disable iff (!arst_n)
      |pend_q |=> ((busy & $past(pend_q)) == $past(pend_q))
   );

endmodule

//--- common/mem_tester_pkg.sv
package mem_tester_pkg;

   // ------------------------------------------------------------
   // Command opcodes
   // ------------------------------------------------------------

   typedef enum logic [1:0] {
      OP_NONE       = 2'b00,  // Reserved, accepted but dropped
      OP_FILL       = 2'b01,  // Write pattern over range
      OP_CHECK      = 2'b10,  // Read back and compare
      OP_FILL_CHECK = 2'b11   // Fill, then check
   } test_op_e;

   // ------------------------------------------------------------
   // Engine FSM states
   // ------------------------------------------------------------

   typedef enum logic [2:0] {
      ST_IDLE  = 3'd0,
      ST_WRITE = 3'd1,
      ST_READ  = 3'd2,
      ST_DONE  = 3'd3  // One cycle, drives done
   } engine_state_e;

   // Per-engine error counter width, saturating
   localparam int ERR_W = 16;

   // Index width for N engines, at least one bit
   function automatic int idx_w(input int n);
      return (n > 1) ? $clog2(n) : 1;
   endfunction

endpackage
